// File: lsu_consts.svh
// little-endian 32-bit data bus only; type code 11 decodes as a byte access
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

//////////////////////////////
// data path width
`define LSU_XLEN 32                // data and byte address width

// access type codes as driven by the decoder
`define LSU_TYPE_WORD 2'b00
`define LSU_TYPE_HALF 2'b01
`define LSU_TYPE_BYTE 2'b10        // 2'b11 also lands on byte

// step from first to second half of a split access
`define LSU_WORD_BYTES 4

// top address nibble that the memory answers with an error
`define LSU_ERR_REGION 4'hF

`endif

// File: lsu_pkg.sv
// widths follow the macros in lsu_consts.svh and assume a 4-byte word
`include "lsu_consts.svh"

package lsu_pkg;

  //////////////////////////////
  // data path vectors
  typedef logic [`LSU_XLEN-1:0] word_t;                     // one data word
  typedef logic [`LSU_XLEN-1:0] addr_t;                     // byte address
  typedef logic [`LSU_WORD_BYTES-1:0] be_t;                 // one enable per byte lane
  typedef logic [$clog2(`LSU_WORD_BYTES)-1:0] offset_t;     // byte offset in a word

  // word, half or byte
  typedef logic [1:0] data_type_t;

  //////////////////////////////
  // controller states
  // only two states since the core never stalls the lsu between grant and rvalid
  typedef enum logic
  {
    IDLE,         // free, may issue a request
    WAIT_RVALID   // one access granted, response still pending
  } lsu_state_e;

endpackage

// File: lsu_req_stage.sv
// purely combinational; the core must hold all ex inputs stable until lsu_ready_ex_o
`timescale 1ns/100ps
`include "lsu_consts.svh"

module lsu_req_stage import lsu_pkg::*;
(
  input  logic       data_req_ex_i,        // access requested by ex stage
  input  logic       data_we_ex_i,         // store when high
  input  data_type_t data_type_ex_i,       // word, half or byte
  input  word_t      data_wdata_ex_i,      // store data as held in the register
  input  offset_t    data_reg_offset_ex_i, // byte offset of the store data in the register
  input  addr_t      operand_a_ex_i,       // base
  input  addr_t      operand_b_ex_i,       // increment
  input  logic       addr_useincr_ex_i,    // a+b when high, else a
  input  logic       data_misaligned_ex_i, // this is the second half of a split access

  output addr_t      addr_o,               // byte address to memory
  output be_t        be_o,                 // byte enables to memory
  output word_t      wdata_o,              // lane-aligned store data
  output logic       misaligned_o,         // first half of a split access seen
  output logic       store_raw_o           // rsp stage keeps the raw word at rvalid
);

  offset_t                 addr_off;       // byte offset of the access
  offset_t                 wdata_off;      // rotation amount for store data
  logic [2*`LSU_XLEN-1:0]  wdata_dbl;      // doubled word, upper half is the rotation

  //////////////////////////////
  // address generation
  assign addr_o   = addr_useincr_ex_i ? (operand_a_ex_i + operand_b_ex_i) : operand_a_ex_i;
  assign addr_off = addr_o[$bits(offset_t)-1:0];

  //////////////////////////////
  // byte enables
  always_comb
  begin
    case (data_type_ex_i)
      `LSU_TYPE_WORD:
      begin
        if (data_misaligned_ex_i)
          be_o = be_t'(4'b1111 >> (3'd4 - {1'b0, addr_off}));  // 0001 / 0011 / 0111
        else
          be_o = be_t'(4'b1111 << addr_off);                  // upper lanes from offset on
      end

      `LSU_TYPE_HALF:
      begin
        if (data_misaligned_ex_i)
          be_o = 4'b0001;                     // only byte 1 of the half is left
        else
          be_o = be_t'(4'b0011 << addr_off);  // offset 3 drops the top lane
      end

      default:
      begin
        be_o = be_t'(4'b0001 << addr_off);    // byte, codes 10 and 11
      end
    endcase
  end

  //////////////////////////////
  // store data rotation
  // register offset moves data toward lane 0, address offset moves it up
  assign wdata_off = addr_off - data_reg_offset_ex_i;  // wraps mod 4
  assign wdata_dbl = {data_wdata_ex_i, data_wdata_ex_i} << {wdata_off, 3'b000};

  // loads leave the write bus quiet
  assign wdata_o = data_we_ex_i ? wdata_dbl[2*`LSU_XLEN-1:`LSU_XLEN] : '0;

  //////////////////////////////
  // misaligned detection
  // only the first half can be flagged, the second one is always in range
  always_comb
  begin
    misaligned_o = 1'b0;

    if (data_req_ex_i && !data_misaligned_ex_i)
    begin
      case (data_type_ex_i)
        `LSU_TYPE_WORD:
        begin
          misaligned_o = (addr_off != 2'b00);   // any nonzero offset spills over
        end
        `LSU_TYPE_HALF:
        begin
          misaligned_o = (addr_off == 2'b11);   // only offset 3 crosses the word
        end
        default:
        begin
          misaligned_o = 1'b0;                  // bytes never split
        end
      endcase
    end
  end

  // either half of a split access means the response word is raw
  assign store_raw_o = misaligned_o | data_misaligned_ex_i;

endmodule

// File: lsu_rsp_stage.sv
// attributes are taken at grant so only one access may be outstanding at a time
`timescale 1ns/100ps
`include "lsu_consts.svh"

module lsu_rsp_stage import lsu_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  input  logic       data_gnt_i,     // memory accepted the access
  input  logic       data_rvalid_i,  // response word present
  input  word_t      data_rdata_i,   // raw word from memory

  input  data_type_t type_i,         // access type at request time
  input  offset_t    offset_i,       // address offset at request time
  input  logic       sign_ext_i,     // sign extend the loaded value
  input  logic       we_i,           // store when high
  input  logic       store_raw_i,    // keep raw word, part of a split access

  output word_t      rdata_o         // aligned and extended load data
);

  data_type_t  type_q;               // type of the access in flight
  offset_t     offset_q;             // its byte offset
  logic        sign_ext_q;
  logic        we_q;

  word_t       rdata_q;              // first half of a split load, else last result
  word_t       rdata_w;              // word candidate
  logic [15:0] rdata_h;              // selected halfword
  logic [7:0]  rdata_b;              // selected byte
  word_t       rdata_h_ext;
  word_t       rdata_b_ext;
  word_t       rdata_ext;            // candidate chosen by type
  word_t       rdata_shift;          // new word moved down by the offset

  //////////////////////////////
  // attribute capture at grant
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      type_q     <= `LSU_TYPE_WORD;
      offset_q   <= '0;
      sign_ext_q <= 1'b0;
      we_q       <= 1'b0;
    end
    else if (data_gnt_i)
    begin
      type_q     <= type_i;
      offset_q   <= offset_i;
      sign_ext_q <= sign_ext_i;
      we_q       <= we_i;
    end
  end

  assign rdata_shift = data_rdata_i >> {offset_q, 3'b000};

  //////////////////////////////
  // candidates
  // word assembled from the low bytes of the new word and the held high bytes
  always_comb
  begin
    if (offset_q == 2'b00)
      rdata_w = data_rdata_i;                                       // aligned, nothing to join
    else
      rdata_w = word_t'({data_rdata_i, rdata_q} >> {offset_q, 3'b000});
  end

  // offset 3 half takes its low byte from the held word
  assign rdata_h = (offset_q == 2'b11) ? {data_rdata_i[7:0], rdata_q[31:24]}
                                       : rdata_shift[15:0];
  assign rdata_b = rdata_shift[7:0];

  // zero or sign extension
  assign rdata_h_ext = {{(`LSU_XLEN-16){sign_ext_q & rdata_h[15]}}, rdata_h};
  assign rdata_b_ext = {{(`LSU_XLEN-8){sign_ext_q & rdata_b[7]}}, rdata_b};

  always_comb
  begin
    case (type_q)
      `LSU_TYPE_WORD: rdata_ext = rdata_w;
      `LSU_TYPE_HALF: rdata_ext = rdata_h_ext;
      default:        rdata_ext = rdata_b_ext;   // byte, 10 and 11
    endcase
  end

  //////////////////////////////
  // held word
  // raw word while a split load is in progress so the second half can join it
  always_ff @(posedge clk)
  begin
    if (data_rvalid_i && !we_q)
    begin
      if (store_raw_i)
        rdata_q <= data_rdata_i;
      else
        rdata_q <= rdata_ext;        // final result stays visible to wb
    end
  end

  // fresh value in the rvalid cycle, held value after
  assign rdata_o = data_rvalid_i ? rdata_ext : rdata_q;

endmodule

// File: lsu_ctrl_fsm.sv
// one outstanding access only; the memory must not grant again before the pending rvalid
`timescale 1ns/100ps

module lsu_ctrl_fsm import lsu_pkg::*;
(
  input  logic clk,
  input  logic rst_n,

  input  logic data_req_ex_i,   // core wants an access
  input  logic data_gnt_i,      // memory accepted it
  input  logic data_rvalid_i,   // response of the pending access

  output logic data_req_o,      // request to memory
  output logic lsu_ready_ex_o,  // ex stage may move on
  output logic lsu_ready_wb_o,  // wb stage may move on
  output logic busy_o           // access requested or in flight
);

  lsu_state_e cs;
  lsu_state_e ns;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      cs <= IDLE;
    else
      cs <= ns;
  end

  //////////////////////////////
  // next state and outputs
  always_comb
  begin
    ns             = cs;
    data_req_o     = 1'b0;
    lsu_ready_ex_o = 1'b1;
    lsu_ready_wb_o = 1'b1;

    case (cs)
      IDLE:
      begin
        data_req_o = data_req_ex_i;
        if (data_req_ex_i)
        begin
          lsu_ready_ex_o = data_gnt_i;            // hold ex until the grant
          if (data_gnt_i)
            ns = WAIT_RVALID;
        end
      end

      WAIT_RVALID:
      begin
        if (data_rvalid_i)
        begin
          // the response frees the slot, so a new request may go out now
          data_req_o = data_req_ex_i;
          if (data_req_ex_i)
            lsu_ready_ex_o = data_gnt_i;
          ns = (data_req_ex_i && data_gnt_i) ? WAIT_RVALID : IDLE;  // back to back
        end
        else
        begin
          lsu_ready_wb_o = 1'b0;                  // wb waits for the data
          lsu_ready_ex_o = !data_req_ex_i;        // no issue while one is pending
        end
      end

      default:
      begin
        ns = IDLE;
      end
    endcase
  end

  assign busy_o = (cs != IDLE) || data_req_o;

endmodule

// File: lsu_top.sv
// memory side follows req/gnt/rvalid with one access in flight; the core re-issues split halves
`timescale 1ns/100ps

module lsu_top import lsu_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  // core side, ex stage
  input  logic       data_req_ex_i,
  input  logic       data_we_ex_i,
  input  data_type_t data_type_ex_i,
  input  word_t      data_wdata_ex_i,
  input  offset_t    data_reg_offset_ex_i,
  input  logic       data_sign_ext_ex_i,
  input  addr_t      operand_a_ex_i,
  input  addr_t      operand_b_ex_i,
  input  logic       addr_useincr_ex_i,
  input  logic       data_misaligned_ex_i,  // second half of a split access

  // core side, results and stalls
  output word_t      data_rdata_ex_o,
  output logic       data_misaligned_o,     // core must re-issue at address + 4
  output logic       lsu_ready_ex_o,
  output logic       lsu_ready_wb_o,
  output logic       busy_o,
  output logic       load_err_o,            // grant cycle only
  output logic       store_err_o,           // grant cycle only

  // memory side
  output logic       data_req_o,
  output addr_t      data_addr_o,
  output logic       data_we_o,
  output be_t        data_be_o,
  output word_t      data_wdata_o,
  input  logic       data_gnt_i,
  input  logic       data_rvalid_i,
  input  logic       data_err_i,            // only with a grant
  input  word_t      data_rdata_i
);

  logic store_raw;                          // split access, keep raw response word

  //////////////////////////////
  // request side
  lsu_req_stage lsu_req_stage_inst
  (
    .data_req_ex_i        (data_req_ex_i),
    .data_we_ex_i         (data_we_ex_i),
    .data_type_ex_i       (data_type_ex_i),
    .data_wdata_ex_i      (data_wdata_ex_i),
    .data_reg_offset_ex_i (data_reg_offset_ex_i),
    .operand_a_ex_i       (operand_a_ex_i),
    .operand_b_ex_i       (operand_b_ex_i),
    .addr_useincr_ex_i    (addr_useincr_ex_i),
    .data_misaligned_ex_i (data_misaligned_ex_i),
    .addr_o               (data_addr_o),
    .be_o                 (data_be_o),
    .wdata_o              (data_wdata_o),
    .misaligned_o         (data_misaligned_o),
    .store_raw_o          (store_raw)
  );

  //////////////////////////////
  // response side
  lsu_rsp_stage lsu_rsp_stage_inst
  (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .type_i        (data_type_ex_i),
    .offset_i      (data_addr_o[$bits(offset_t)-1:0]),  // offset of the granted address
    .sign_ext_i    (data_sign_ext_ex_i),
    .we_i          (data_we_ex_i),
    .store_raw_i   (store_raw),
    .rdata_o       (data_rdata_ex_o)
  );

  lsu_ctrl_fsm lsu_ctrl_fsm_inst
  (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_req_o     (data_req_o),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o)
  );

  assign data_we_o = data_we_ex_i;

  // error split by direction of the granted access
  assign load_err_o  = data_gnt_i && data_err_i && !data_we_ex_i;
  assign store_err_o = data_gnt_i && data_err_i && data_we_ex_i;

endmodule

// File: lsu_asserts.sv
// FSM_CHECKS selects the controller checks, else the bus checks of the top level
`timescale 1ns/100ps

module lsu_asserts import lsu_pkg::*;
#(
  parameter bit FSM_CHECKS = 1'b0
)
(
  input logic  clk,
  input logic  rst_n,
  input logic  req,       // request to memory
  input logic  gnt,
  input logic  rvalid,
  input logic  err,
  input logic  waiting,   // controller in WAIT_RVALID
  input addr_t addr
);

  if (FSM_CHECKS)
  begin : g_fsm
    // one outstanding access, a new grant needs the old response
    a_gnt_wait: assert property (@(posedge clk) disable iff (!rst_n)
      (gnt && waiting) |-> rvalid) else $error("grant while an access is pending");
    a_no_rvalid_idle: assert property (@(posedge clk) disable iff (!rst_n)
      !waiting |-> !rvalid) else $error("rvalid with nothing outstanding");
  end
  else
  begin : g_bus
    a_err_gnt: assert property (@(posedge clk) disable iff (!rst_n)
      err |-> gnt) else $error("memory error without grant");
    a_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
      req |-> !$isunknown(addr)) else $error("unknown address during request");
  end

endmodule

bind lsu_ctrl_fsm lsu_asserts #(.FSM_CHECKS(1'b1)) fsm_asserts_inst
(
  .clk (clk), .rst_n (rst_n), .req (data_req_o), .gnt (data_gnt_i),
  .rvalid (data_rvalid_i), .err (1'b0), .waiting (cs == WAIT_RVALID), .addr ('0)
);

bind lsu_top lsu_asserts #(.FSM_CHECKS(1'b0)) bus_asserts_inst
(
  .clk (clk), .rst_n (rst_n), .req (data_req_o), .gnt (data_gnt_i),
  .rvalid (data_rvalid_i), .err (data_err_i), .waiting (1'b0), .addr (data_addr_o)
);

// File: lsu_tb.sv
// single-threaded core model; memory holds 1 KB so test addresses stay below 0x3f8 or in the error region
`timescale 1ns/100ps
`include "lsu_consts.svh"

module lsu_tb import lsu_pkg::*;
();

  localparam int N_ACC   = 140;  // upper bound on accesses issued below
  localparam int RST_CYC = 8;

  logic clk;
  logic rst_n;

  // core side
  logic       req;
  logic       we;
  data_type_t dtype;
  word_t      wdata;
  offset_t    regoff;
  logic       sign;
  addr_t      opa;
  addr_t      opb;
  logic       useincr;
  logic       mis_ex;              // second half marker
  word_t      rdata_ex;
  logic       mis_o;
  logic       ready_ex;
  logic       ready_wb;
  logic       busy;
  logic       load_err;
  logic       store_err;

  // memory side
  logic  mreq;
  addr_t maddr;
  logic  mwe;
  be_t   mbe;
  word_t mwdata;
  logic  gnt;
  logic  rvalid;
  logic  merr;
  word_t mrdata;

  word_t       mem  [0:255];       // memory model with one word per index
  logic [7:0]  shad [0:1023];      // expected bytes
  logic [31:0] rng = 32'h6384_1a21;
  int          errors = 0;
  int          rv_cnt = 0;         // rvalids seen by the core
  logic        hold_gnt = 1'b0;    // memory withholds grant while high
  int          rv_left = 0;        // cycles to the pending rvalid
  int          gwait = -1;         // grant delay of the current request or -1 when none drawn
  word_t       rd_word;

  lsu_top lsu_top_inst
  (
    .clk (clk), .rst_n (rst_n),
    .data_req_ex_i (req), .data_we_ex_i (we), .data_type_ex_i (dtype),
    .data_wdata_ex_i (wdata), .data_reg_offset_ex_i (regoff), .data_sign_ext_ex_i (sign),
    .operand_a_ex_i (opa), .operand_b_ex_i (opb), .addr_useincr_ex_i (useincr),
    .data_misaligned_ex_i (mis_ex),
    .data_rdata_ex_o (rdata_ex), .data_misaligned_o (mis_o), .lsu_ready_ex_o (ready_ex),
    .lsu_ready_wb_o (ready_wb), .busy_o (busy), .load_err_o (load_err),
    .store_err_o (store_err),
    .data_req_o (mreq), .data_addr_o (maddr), .data_we_o (mwe), .data_be_o (mbe),
    .data_wdata_o (mwdata), .data_gnt_i (gnt), .data_rvalid_i (rvalid),
    .data_err_i (merr), .data_rdata_i (mrdata)
  );

  //////////////////////////////
  // helpers
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function logic [31:0] draw();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic int size_of(input data_type_t t);
    if (t == `LSU_TYPE_WORD)
      return 4;
    else if (t == `LSU_TYPE_HALF)
      return 2;
    return 1;                      // 10 and 11
  endfunction

  function automatic logic in_err_region(input addr_t a);
    return a[31:28] == `LSU_ERR_REGION;
  endfunction

  // lanes touched by this part of the access
  function automatic be_t be_rule(input data_type_t t, input offset_t off, input logic second);
    be_t b;
    b = '0;
    for (int i = 0; i < size_of(t); i++)
    begin
      if (!second && int'(off) + i < 4)
        b[int'(off) + i] = 1'b1;
      else if (second && int'(off) + i >= 4)
        b[int'(off) + i - 4] = 1'b1;
    end
    return b;
  endfunction

  // expected load value from the byte shadow
  function automatic word_t ref_load(input addr_t a, input data_type_t t, input logic sx);
    word_t v;
    int    n;
    v = '0;
    n = size_of(t);
    for (int i = 0; i < n; i++)
      v[8*i +: 8] = shad[(int'(a[9:0]) + i) & 1023];
    if (sx && n < 4 && v[8*n-1])
    begin
      for (int j = 8*n; j < 32; j++)
        v[j] = 1'b1;
    end
    return v;
  endfunction

  //////////////////////////////
  // compare tasks
  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp)
    begin
      errors++;
      $display("FAIL %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_be(input string name, input be_t exp, input be_t act);
    if (act !== exp)
    begin
      errors++;
      $display("FAIL %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      errors++;
      $display("FAIL %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  //////////////////////////////
  // clock and watchdog
  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial
  begin
    #((N_ACC * 12 + RST_CYC) * 8);
    $display("timeout, the accesses did not complete in the allowed time");
    $display("Test failed");
    $finish;
  end

  //////////////////////////////
  // memory model
  initial
  begin
    for (int i = 0; i < 256; i++)
    begin
      mem[i] = {8'(i) ^ 8'h5a, ~8'(i), 8'(i) + 8'h33, 8'(i)};
      for (int k = 0; k < 4; k++)
        shad[4*i + k] = mem[i][8*k +: 8];
    end
    forever
    begin
      @(posedge clk);
      #2;
      gnt    = 1'b0;
      merr   = 1'b0;
      rvalid = 1'b0;
      if (rv_left > 0)
      begin
        rv_left--;
        if (rv_left == 0)
        begin
          rvalid = 1'b1;
          mrdata = rd_word;
        end
      end
      #1;                                      // req may follow rvalid in this cycle
      if (mreq && rv_left == 0 && !hold_gnt)
      begin
        if (gwait < 0)
          gwait = int'(draw() % 3);
        if (gwait == 0)
        begin
          gnt   = 1'b1;
          merr  = in_err_region(maddr);
          gwait = -1;
        end
        else
          gwait--;
      end
      @(negedge clk);
      if (gnt && mreq)                         // accepted
      begin
        rv_left = 1 + int'(draw() % 2);
        rd_word = '0;
        if (!merr && mwe)
        begin
          for (int k = 0; k < 4; k++)
            if (mbe[k])
              mem[maddr[9:2]][8*k +: 8] = mwdata[8*k +: 8];
        end
        else if (!merr)
          rd_word = mem[maddr[9:2]];
      end
    end
  end

  //////////////////////////////
  // bus monitor sampling at the falling edge
  initial
  begin : bus_monitor
    addr_t   ea;
    offset_t off;
    logic    pend;                             // granted access still waiting for rvalid
    pend = 1'b0;
    @(posedge rst_n);
    forever
    begin
      @(negedge clk);
      ea  = useincr ? opa + opb : opa;
      off = ea[1:0];
      if (mreq)
        check_word("data_addr_o", ea, maddr);
      if (mreq && gnt)
      begin
        check_be("data_be_o", be_rule(dtype, off, mis_ex), mbe);
        check_flag("data_misaligned_o", !mis_ex && (int'(off) + size_of(dtype) > 4), mis_o);
        check_flag("load_err_o", in_err_region(ea) && !we, load_err);
        check_flag("store_err_o", in_err_region(ea) && we, store_err);
      end
      else
      begin
        check_flag("load_err_o", 1'b0, load_err);   // grant cycle only
        check_flag("store_err_o", 1'b0, store_err);
      end
      check_flag("lsu_ready_wb_o", !(pend && !rvalid), ready_wb);
      pend = (mreq && gnt) || (pend && !rvalid);
    end
  end

  //////////////////////////////
  // core side
  task automatic tick();
    @(negedge clk);
    if (rvalid)
      rv_cnt++;
  endtask

  task automatic wait_ready();
    do
      tick();
    while (!ready_ex);
  endtask

  task automatic run_access(input logic st, input data_type_t t, input addr_t a,
                            input addr_t b, input logic inc, input word_t wd,
                            input offset_t ro, input logic sx);
    addr_t ad;
    int    n;
    int    parts;
    int    tgt;
    word_t exp;
    logic  err;
    ad    = inc ? a + b : a;
    n     = size_of(t);
    parts = (int'(ad[1:0]) + n > 4) ? 2 : 1;
    err   = in_err_region(ad);
    exp   = ref_load(ad, t, sx);
    if (st && !err)
    begin
      for (int i = 0; i < n; i++)
        shad[(int'(ad[9:0]) + i) & 1023] = wd[8*((int'(ro) + i) % 4) +: 8];
    end
    tgt = rv_cnt + parts;
    @(posedge clk);
    #1;
    req     = 1'b1;
    we      = st;
    dtype   = t;
    opa     = a;
    opb     = b;
    useincr = inc;
    wdata   = wd;
    regoff  = ro;
    sign    = sx;
    mis_ex  = 1'b0;
    wait_ready();
    if (parts == 2)
    begin
      @(posedge clk);
      #1;
      opa    = a + `LSU_WORD_BYTES;     // low bits unchanged
      mis_ex = 1'b1;
      wait_ready();
    end
    @(posedge clk);
    #1;
    req    = 1'b0;
    mis_ex = 1'b0;
    while (rv_cnt < tgt)
      tick();
    if (!st && !err)
    begin
      check_word("data_rdata_ex_o", exp, rdata_ex);   // fresh data in the rvalid cycle
      tick();
      check_word("data_rdata_ex_o", exp, rdata_ex);   // held register one cycle later
    end
  endtask

  //////////////////////////////
  // stimulus
  initial
  begin : stimulus
    addr_t ad;
    req     = 1'b0;
    we      = 1'b0;
    dtype   = `LSU_TYPE_WORD;
    wdata   = '0;
    regoff  = '0;
    sign    = 1'b0;
    opa     = '0;
    opb     = '0;
    useincr = 1'b0;
    mis_ex  = 1'b0;
    gnt     = 1'b0;
    rvalid  = 1'b0;
    merr    = 1'b0;
    mrdata  = '0;
    rst_n = 1'b0;
    repeat (RST_CYC) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_flag("data_req_o", 1'b0, mreq);
    check_flag("busy_o", 1'b0, busy);
    check_flag("lsu_ready_ex_o", 1'b1, ready_ex);
    check_flag("lsu_ready_wb_o", 1'b1, ready_wb);

    // every type, offset and sign rule
    for (int t = 0; t < 4; t++)
      for (int o = 0; o < 4; o++)
        for (int s = 0; s < 2; s++)
          run_access(1'b0, data_type_t'(t), 32'h80 + 32'(t*16), 32'(o), 1'b1, '0, '0, s[0]);

    // stores then word reads of both touched words
    for (int t = 0; t < 4; t++)
      for (int o = 0; o < 4; o++)
      begin
        ad = 32'h200 + 32'(t*16) + 32'(o);
        run_access(1'b1, data_type_t'(t), ad, '0, 1'b0, draw(), offset_t'(draw()), 1'b0);
        run_access(1'b0, `LSU_TYPE_WORD, {ad[31:2], 2'b00}, '0, 1'b0, '0, '0, 1'b0);
        run_access(1'b0, `LSU_TYPE_WORD, {ad[31:2], 2'b00} + 4, '0, 1'b0, '0, '0, 1'b0);
      end

    // random mix
    for (int i = 0; i < 40; i++)
      run_access(draw() % 2 == 1, data_type_t'(draw()), draw() & 32'h1f7, draw() & 32'h7,
                 draw() % 2 == 1, draw(), offset_t'(draw()), draw() % 2 == 1);

    // error region
    run_access(1'b0, `LSU_TYPE_WORD, 32'hf000_0040, '0, 1'b0, '0, '0, 1'b0);
    run_access(1'b1, `LSU_TYPE_WORD, 32'hf000_0040, 32'h4, 1'b1, draw(), '0, 1'b0);
    run_access(1'b0, `LSU_TYPE_HALF, 32'hf000_0082, '0, 1'b0, '0, '0, 1'b1);
    run_access(1'b1, `LSU_TYPE_BYTE, 32'hf000_0083, '0, 1'b0, draw(), 2'd1, 1'b0);

    // back-pressure with grant withheld
    hold_gnt = 1'b1;
    fork
      run_access(1'b0, `LSU_TYPE_WORD, 32'h300, '0, 1'b0, '0, '0, 1'b0);
      begin
        repeat (5)
        begin
          @(negedge clk);
          check_flag("data_req_o", 1'b1, mreq);
          check_flag("lsu_ready_ex_o", 1'b0, ready_ex);
          check_flag("busy_o", 1'b1, busy);
        end
        hold_gnt = 1'b0;
      end
    join

    $display("all accesses done, %0d errors", errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: project.f
+incdir+.
lsu_pkg.sv
lsu_req_stage.sv
lsu_rsp_stage.sv
lsu_ctrl_fsm.sv
lsu_top.sv
lsu_asserts.sv
lsu_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module lsu_tb -f project.f -Mdir obj_dir -o lsu_tb
	./obj_dir/lsu_tb | tee /dev/stderr | grep -q "Test passed"

clean:
	rm -rf obj_dir
